// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Frame lengths on the SPI bus
  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;

  // Command fields
  localparam int ADDR_WIDTH = 3;
  localparam int DATA_WIDTH = 8;

  // Field order matches the bit order on mosi, rw goes out first
  typedef struct packed {
    logic                  rw;    // 1 selects a write, 0 a read
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;  // Ignored by a read
  } spi_cmd_t;

  typedef struct packed {
    logic [READ_WIDTH-1:0] rdata;
  } spi_rsp_t;

  // Transfer FSM of the master
  typedef enum logic [3:0] {
    IDLE,
    JUDGE,
    W_START,
    W_DATA,
    W_FINISH,
    R_START,
    WR_DATA,
    RR_DATA,
    R_FINISH
  } spi_state_e;

endpackage

`default_nettype wire

// File: spi_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t in_cmd,
  input  logic              in_valid,
  output logic              in_ready,
  output spi_pkg::spi_cmd_t out_cmd,
  output logic              out_valid,
  input  logic              out_ready
);

  // A one-entry queue still needs a one-bit pointer
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  spi_pkg::spi_cmd_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(FIFO_DEPTH)); // Full blocks the push even if a pop is due
  assign out_valid = (count != '0);
  assign out_cmd   = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither leave the level alone
      endcase
    end
  end

endmodule

`default_nettype wire

// File: spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen #(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  localparam int CNT_W = $clog2(CLK_DIV);

  logic [CNT_W-1:0] cnt;

  // Strobes are registered with sclk, so each one is high in the first
  // clk cycle that sees the new sclk level
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt       <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!en)
    begin
      // Parked low, so the first edge after enabling is a rise
      cnt       <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      if (cnt == CNT_W'(CLK_DIV - 1))
      begin
        cnt       <= '0;
        sclk      <= ~sclk;
        sclk_rise <= ~sclk;
        sclk_fall <= sclk;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int CLK_DIV = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output logic              sclk_en,
  input  logic              sclk_rise,
  input  logic              sclk_fall,
  output logic              cs_n,
  output logic              mosi,
  input  logic              miso,
  output spi_pkg::spi_rsp_t rsp,
  output logic              rsp_valid,
  input  logic              rsp_ready
);

  localparam int CMD_W   = spi_pkg::CMD_WIDTH;
  localparam int READ_W  = spi_pkg::READ_WIDTH;
  localparam int BIT_W   = $clog2(CMD_W + 1);
  localparam int TIMER_W = $clog2(2 * CLK_DIV);

  spi_pkg::spi_state_e state;
  spi_pkg::spi_state_e state_next;

  spi_pkg::spi_cmd_t   cmd_buf;
  logic [CMD_W-1:0]    tx_shift;
  logic [READ_W-1:0]   rx_shift;
  logic [BIT_W-1:0]    bit_cnt;
  logic [TIMER_W-1:0]  timer;

  logic in_start;
  logic in_finish;
  logic in_shift;
  logic half_done;
  logic gap_done;
  logic cmd_bits_done;
  logic rd_bits_done;

  assign in_start  = (state == spi_pkg::W_START) || (state == spi_pkg::R_START);
  assign in_finish = (state == spi_pkg::W_FINISH) || (state == spi_pkg::R_FINISH);
  assign in_shift  = (state == spi_pkg::W_DATA) || (state == spi_pkg::WR_DATA);

  // One sclk half-period, and the cs_n high gap of a full period
  assign half_done = (timer == TIMER_W'(CLK_DIV - 1));
  assign gap_done  = (timer == TIMER_W'(2 * CLK_DIV - 1));

  // The last fall after the final rise of a phase
  assign cmd_bits_done = sclk_fall && (bit_cnt == BIT_W'(CMD_W));
  assign rd_bits_done  = sclk_fall && (bit_cnt == BIT_W'(READ_W));

  assign cmd_ready = (state == spi_pkg::IDLE);
  assign mosi      = tx_shift[CMD_W-1];   // MSB first

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= spi_pkg::IDLE;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      spi_pkg::IDLE:
        if (cmd_valid)
          state_next = spi_pkg::JUDGE;
      spi_pkg::JUDGE:
        state_next = cmd_buf.rw ? spi_pkg::W_START : spi_pkg::R_START;
      spi_pkg::W_START:
        if (half_done)
          state_next = spi_pkg::W_DATA;
      spi_pkg::W_DATA:
        if (cmd_bits_done)
          state_next = spi_pkg::W_FINISH;
      spi_pkg::W_FINISH:
        if (cs_n && gap_done)
          state_next = spi_pkg::IDLE;
      spi_pkg::R_START:
        if (half_done)
          state_next = spi_pkg::WR_DATA;
      spi_pkg::WR_DATA:
        if (cmd_bits_done)
          state_next = spi_pkg::RR_DATA;  // Clock keeps running into the read bits
      spi_pkg::RR_DATA:
        if (rd_bits_done)
          state_next = spi_pkg::R_FINISH;
      spi_pkg::R_FINISH:
        if (cs_n && gap_done && !rsp_valid)
          state_next = spi_pkg::IDLE;
      default:
        state_next = spi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs_n      <= 1'b1;
      sclk_en   <= 1'b0;
      bit_cnt   <= '0;
      timer     <= '0;
      tx_shift  <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      // Timer restarts in every state and at cs_n rising
      if (state_next != state)
        timer <= '0;
      else if (in_finish && !cs_n && half_done)
        timer <= '0;
      else if ((in_start || in_finish) && !gap_done)
        timer <= timer + 1'b1;

      if (state_next != state)
        bit_cnt <= '0;
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 1'b1;

      if (state == spi_pkg::JUDGE)
      begin
        cs_n     <= 1'b0;
        tx_shift <= cmd_buf;            // Bit 11 is on mosi for the whole setup
      end
      else if (in_finish && !cs_n && half_done)
      begin
        cs_n <= 1'b1;
      end

      if (in_shift && sclk_fall)
        tx_shift <= {tx_shift[CMD_W-2:0], 1'b0};

      if (in_start && half_done)
        sclk_en <= 1'b1;
      else if (((state == spi_pkg::W_DATA) && cmd_bits_done) ||
               ((state == spi_pkg::RR_DATA) && rd_bits_done))
        sclk_en <= 1'b0;

      if ((state == spi_pkg::RR_DATA) && rd_bits_done)
        rsp_valid <= 1'b1;
      else if (rsp_valid && rsp_ready)
        rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == spi_pkg::IDLE) && cmd_valid)
      cmd_buf <= cmd;
    if ((state == spi_pkg::RR_DATA) && sclk_rise)
      rx_shift <= {rx_shift[READ_W-2:0], miso};
    // Held until the host takes it
    if ((state == spi_pkg::RR_DATA) && rd_bits_done)
      rsp.rdata <= rx_shift;
  end

endmodule

`default_nettype wire

// File: spi_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module spi_subsystem #(
  parameter int CLK_DIV    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output spi_pkg::spi_rsp_t rsp,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic              sclk,
  output logic              cs_n,
  output logic              mosi,
  input  logic              miso
);

  spi_pkg::spi_cmd_t q_cmd;
  logic              q_valid;
  logic              q_ready;
  logic              sclk_en;
  logic              sclk_rise;
  logic              sclk_fall;

  spi_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_cmd    (cmd),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_cmd   (q_cmd),
    .out_valid (q_valid),
    .out_ready (q_ready)
  );

  spi_sclk_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_sclk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (sclk_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_master #(
    .CLK_DIV (CLK_DIV)
  ) u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (q_cmd),
    .cmd_valid (q_valid),
    .cmd_ready (q_ready),
    .sclk_en   (sclk_en),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

endmodule

`default_nettype wire

// File: spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  localparam int CMD_W   = spi_pkg::CMD_WIDTH;
  localparam int FRAME_W = spi_pkg::CMD_WIDTH + spi_pkg::READ_WIDTH;

  logic [7:0]        regs [8] = '{default: 8'h00};
  spi_pkg::spi_cmd_t cmd_sr   = '0;
  int                bit_cnt  = 0;
  logic              miso_q   = 1'b0;

  assign miso = miso_q;

  // sclk is always low when cs_n falls, so a low sclk here marks a new frame
  always @(negedge cs_n or posedge sclk)
  begin
    if (!sclk)
      bit_cnt = 0;
    else if (!cs_n)
    begin
      if (bit_cnt < CMD_W)
        cmd_sr = {cmd_sr[CMD_W-2:0], mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(negedge sclk or posedge cs_n)
  begin
    if (cs_n === 1'b1)
    begin
      // A write lands only when the frame held exactly the command bits
      if (bit_cnt == CMD_W && cmd_sr.rw)
        regs[cmd_sr.addr] = cmd_sr.data;
      miso_q = 1'b0;
    end
    else if (!cs_n && !cmd_sr.rw && bit_cnt >= CMD_W && bit_cnt < FRAME_W)
      miso_q = regs[cmd_sr.addr][FRAME_W - 1 - bit_cnt];  // MSB first
  end

endmodule

`default_nettype wire

// File: tb_spi_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_subsystem;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam int READY_ALWAYS   = 0;
  localparam int READY_HOLD     = 1;
  localparam int READY_RANDOM   = 2;

  logic              clk = 1'b0;
  logic              rst_n;
  spi_pkg::spi_cmd_t cmd;
  logic              cmd_valid;
  logic              cmd_ready;
  spi_pkg::spi_rsp_t rsp;
  logic              rsp_valid;
  logic              rsp_ready;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  logic              miso;

  int         ready_mode;
  logic [7:0] ref_regs [8];
  bit         bus_rw [$];         // rw bit of every accepted command, in order
  logic [7:0] exp_rsp [$];
  int         frames_seen    = 0;
  int         rsp_seen       = 0;
  int         rise_cnt       = 0;
  logic       sclk_prev      = 1'b0;
  logic       cs_n_prev      = 1'b1;
  logic       mosi_prev      = 1'b0;
  logic       rsp_valid_prev = 1'b0;
  logic       rsp_ready_prev = 1'b0;
  logic [7:0] rsp_prev       = '0;

  always #5 clk = ~clk;

  spi_subsystem #(
    .CLK_DIV    (4),
    .FIFO_DEPTH (4)
  ) u_spi_subsystem (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_slave_model u_slave (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  task automatic stop_on_error(input string line);
    $display("TB FAILED");
    $display("%s", line);
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else stop_on_error($sformatf("Fail at %0t: %s expected 0x%0h, got 0x%0h",
                                 $time, name, expected, actual));
  endtask

  // sclk may only run inside a cs_n frame
  sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> !cs_n)
    else stop_on_error($sformatf("Fail at %0t: cs_n expected 0x0, got 0x1 with sclk high",
                                 $time));

  // While a response waits no new frame may open
  bus_quiet: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid && cs_n |=> cs_n)
    else stop_on_error($sformatf("Fail at %0t: cs_n expected 0x1, got 0x0 with rsp pending",
                                 $time));

  // Updates the reference model at the point of acceptance
  task automatic send_cmd(input logic rw, input logic [2:0] addr, input logic [7:0] data);
    int waited;
    waited    = 0;
    cmd.rw    = rw;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready)
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_on_error("Timed out waiting for the command port to accept a command");
      @(negedge clk);
    end
    bus_rw.push_back(rw);
    if (rw)
      ref_regs[addr] = data;
    else
      exp_rsp.push_back(ref_regs[addr]);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (frames_seen != bus_rw.size() || rsp_seen != exp_rsp.size())
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_on_error("Timed out waiting for the outstanding transfers to finish");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_back_pressure();
    int waited;
    waited     = 0;
    ready_mode = READY_HOLD;
    @(posedge clk);
    #1;
    send_cmd(1'b0, 3'd3, 8'h00);
    for (int i = 0; i < 4; i++)
      send_cmd(1'b1, 3'(i), 8'($urandom));
    @(negedge clk);
    while (!(rsp_valid && cs_n))
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_on_error("Timed out waiting for the held read response");
      @(negedge clk);
    end
    repeat (50)
    begin
      check_value("cmd_ready", 1'b0, cmd_ready);  // Queue is full behind the stalled read
      check_value("cs_n", 1'b1, cs_n);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ready_mode = READY_ALWAYS;
    wait_drained();
  endtask

  task automatic run_random_traffic(input int count);
    ready_mode = READY_RANDOM;
    for (int i = 0; i < count; i++)
    begin
      send_cmd(1'($urandom_range(1)), 3'($urandom), 8'($urandom));
      repeat ($urandom_range(3))
      begin
        @(posedge clk);
        #1;
      end
    end
    wait_drained();
    ready_mode = READY_ALWAYS;
  endtask

  initial
  begin
    rsp_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (ready_mode == READY_HOLD)
        rsp_ready = 1'b0;
      else if (ready_mode == READY_RANDOM)
        rsp_ready = ($urandom_range(3) != 0);
      else
        rsp_ready = 1'b1;
    end
  end

  // Bus and response monitor, sampled mid-cycle where every signal is settled
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (rsp_valid_prev && !rsp_ready_prev)
      begin
        check_value("rsp_valid", 1'b1, rsp_valid);
        check_value("rsp", rsp_prev, rsp.rdata);
      end
      if (rsp_valid && rsp_ready)
      begin
        if (rsp_seen >= exp_rsp.size())
          stop_on_error("A read response came back with no read outstanding");
        check_value("rsp", exp_rsp[rsp_seen], rsp.rdata);
        rsp_seen++;
      end
      if (sclk && !sclk_prev)
        check_value("mosi", mosi_prev, mosi);
      if (!cs_n && cs_n_prev)
        rise_cnt = 0;
      else if (!cs_n && sclk && !sclk_prev)
        rise_cnt++;
      if (cs_n && !cs_n_prev)
      begin
        if (frames_seen >= bus_rw.size())
          stop_on_error("cs_n framed a transfer that was never issued");
        check_value("sclk rise count",
                    bus_rw[frames_seen] ? spi_pkg::CMD_WIDTH
                                        : spi_pkg::CMD_WIDTH + spi_pkg::READ_WIDTH,
                    rise_cnt);
        frames_seen++;
      end
    end
    sclk_prev      = sclk;
    cs_n_prev      = cs_n;
    mosi_prev      = mosi;
    rsp_valid_prev = rsp_valid;
    rsp_ready_prev = rsp_ready;
    rsp_prev       = rsp.rdata;
  end

  initial
  begin
    void'($urandom(96409));
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_valid  = 1'b0;
    ready_mode = READY_ALWAYS;
    foreach (ref_regs[i])
      ref_regs[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cs_n", 1'b1, cs_n);
    check_value("sclk", 1'b0, sclk);
    check_value("rsp_valid", 1'b0, rsp_valid);
    check_value("cmd_ready", 1'b1, cmd_ready);
    @(posedge clk);
    #1;

    send_cmd(1'b1, 3'd3, 8'($urandom));
    send_cmd(1'b0, 3'd3, 8'h00);
    send_cmd(1'b0, 3'd6, 8'h00);           // Never written, reads back zero
    wait_drained();

    // Two writes to address 5 show that the queue keeps order
    send_cmd(1'b1, 3'd0, 8'($urandom));
    send_cmd(1'b1, 3'd1, 8'($urandom));
    send_cmd(1'b1, 3'd5, 8'($urandom));
    send_cmd(1'b1, 3'd5, 8'($urandom));
    for (int a = 0; a < 8; a++)
      send_cmd(1'b0, 3'(a), 8'h00);
    wait_drained();

    check_back_pressure();
    run_random_traffic(40);

    if (frames_seen == bus_rw.size() && rsp_seen == exp_rsp.size())
    begin
      $display("TB PASSED");
      $finish;
    end
    else
      stop_on_error("Transfers were still outstanding at the end of the run");
  end

endmodule

`default_nettype wire

// File: project.f
spi_pkg.sv
spi_cmd_fifo.sv
spi_sclk_gen.sv
spi_master.sv
spi_subsystem.sv
spi_slave_model.sv
tb_spi_subsystem.sv

// File: Bender.yml
package:
  name: spi_subsystem

sources:
  - files:
      - spi_pkg.sv
      - spi_cmd_fifo.sv
      - spi_sclk_gen.sv
      - spi_master.sv
      - spi_subsystem.sv
  - target: test
    files:
      - spi_slave_model.sv
      - tb_spi_subsystem.sv
